// File: common/dma_ch_consts.svh
`ifndef DMA_CH_CONSTS_SVH
`define DMA_CH_CONSTS_SVH

// Address width of both channel FIFOs.
// The FIFO depth is two to this power, so 9 gives 512 entries.
`define DMA_CH_FIFO_AW 9

// Number of entries from either end of the FIFO at which the
// almost_empty and almost_full flags switch.
// The DMA uses these as its early stop hints.
`define DMA_CH_ALMOST_MARGIN 4

// Width of the result word counter seen by the DMA.
// It wraps silently, as the DMA only samples it per job.
`define DMA_CH_OCNT_W 16

`endif

// File: common/dma_side_pkg.sv
package dma_side_pkg;

   // The DMA moves data as two 32-bit lanes.
   // The hi lane maps to the upper half of a 64-bit module word.
   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
   } dma_word_t;

   // One source FIFO entry, a DMA word plus its end of job marker.
   typedef struct packed {
      logic      last;
      dma_word_t word;
   } src_entry_t;

   // Fetch hints for the source side.
   // start asks for more data while the FIFO is below half full.
   // stop warns that the FIFO is almost full.
   typedef struct packed {
      logic start;
      logic stop;
   } dma_src_ctl_t;

   // Write-back hints for the destination side.
   // last is set while the head entry is the final result.
   typedef struct packed {
      logic start;
      logic stop;
      logic last;
   } dma_dst_ctl_t;

endpackage

// File: common/mod_side_pkg.sv
package mod_side_pkg;

   // A word as the processing module sees it.
   // The same layout is stored in the destination FIFO.
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } mod_entry_t;

   // Fill level flags of a channel FIFO.
   // All of them are decoded from the occupancy count.
   typedef struct packed {
      // Count is zero.
      logic empty;
      // Count is at most the almost margin.
      logic almost_empty;
      // Count is at least half the depth.
      logic half_full;
      // Count is at least depth minus the almost margin.
      logic almost_full;
      // Count equals the depth.
      logic full;
   } fifo_flags_t;

   // Flag set of an empty FIFO, as seen right after reset.
   // Only empty and almost_empty are high here.
   localparam fifo_flags_t FLAGS_RESET = '{
      empty:        1'b1,
      almost_empty: 1'b1,
      default:      1'b0
   };

endpackage

// File: src/tpram.sv
`timescale 1ns/1ps

module tpram #(
   parameter type word_t = logic [63:0],
   parameter int  AW     = 9
) (
   input  logic          wb_clk_i,
   input  logic          m_reset,
   input  logic          we_i,
   input  logic [AW-1:0] waddr_i,
   input  word_t         wdata_i,
   input  logic [AW-1:0] raddr_i,
   output word_t         rdata_o
);

   localparam int DEPTH = 1 << AW;

   word_t mem [DEPTH];

   always_ff @(posedge wb_clk_i)
   begin
      if (we_i)
      begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Registered read port.
   // On a collision the write data is forwarded, so a word written
   // into an empty FIFO shows on the output right after the same edge.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         rdata_o <= '0;
      else if (we_i && (waddr_i == raddr_i))
         rdata_o <= wdata_i;
      else
         rdata_o <= mem[raddr_i];
   end

endmodule

// File: ch_fifo/ch_fifo.sv
`timescale 1ns/1ps
`include "dma_ch_consts.svh"

module ch_fifo #(
   parameter type payload_t = logic [64:0]
) (
   input  logic                      wb_clk_i,
   input  logic                      m_reset,
   input  logic                      push_i,
   input  logic                      pop_i,
   input  payload_t                  din_i,
   output payload_t                  head_o,
   output mod_side_pkg::fifo_flags_t flags_o
);

   localparam int AW = `DMA_CH_FIFO_AW;
   // The count needs one extra bit to tell full from empty.
   localparam int CW = AW + 1;

   localparam logic [CW-1:0] DEPTH    = CW'(1) << AW;
   localparam logic [CW-1:0] HALF_LVL = DEPTH >> 1;
   localparam logic [CW-1:0] AE_LVL   = CW'(`DMA_CH_ALMOST_MARGIN);
   localparam logic [CW-1:0] AF_LVL   = DEPTH - AE_LVL;

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] rd_ptr_nxt;
   logic [CW-1:0] count;
   logic          do_push;
   logic          do_pop;

   // A push into a full FIFO and a pop from an empty one are dropped.
   // With both strobes on a full FIFO only the pop goes through, and on
   // an empty FIFO only the push does.
   assign do_push = push_i && !flags_o.full;
   assign do_pop  = pop_i && !flags_o.empty;

   // The RAM reads at the pointer as it will be after this edge, so
   // the registered RAM output always holds the current head.
   assign rd_ptr_nxt = rd_ptr + AW'(do_pop);

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         rd_ptr <= rd_ptr_nxt;
      end
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         count <= '0;
      else
      begin
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Flags come straight from the count register.
   always_comb
   begin
      flags_o.empty        = (count == '0);
      flags_o.almost_empty = (count <= AE_LVL);
      flags_o.half_full    = (count >= HALF_LVL);
      flags_o.almost_full  = (count >= AF_LVL);
      flags_o.full         = (count == DEPTH);
   end

   // On a push into an empty FIFO the write address equals the next
   // read address, so the RAM forwards the new entry to head_o.
   tpram #(
      .word_t (payload_t),
      .AW     (AW)
   ) ram_i (
      .wb_clk_i (wb_clk_i),
      .m_reset  (m_reset),
      .we_i     (do_push),
      .waddr_i  (wr_ptr),
      .wdata_i  (din_i),
      .raddr_i  (rd_ptr_nxt),
      .rdata_o  (head_o)
   );

endmodule

// File: src/dma_ch.sv
`timescale 1ns/1ps
`include "dma_ch_consts.svh"

module dma_ch (
   input  logic                        wb_clk_i,
   input  logic                        m_reset,

   // DMA side, source path.
   input  logic                        src_xfer_i,
   input  logic                        src_last_i,
   input  dma_side_pkg::dma_word_t     src_word_i,
   output dma_side_pkg::dma_src_ctl_t  src_ctl_o,

   // DMA side, destination path.
   input  logic                        dst_xfer_i,
   output dma_side_pkg::dma_word_t     dst_word_o,
   output dma_side_pkg::dma_dst_ctl_t  dst_ctl_o,

   // Module side, source path.
   input  logic                        m_src_getn_i,
   output mod_side_pkg::mod_entry_t    m_src_o,
   output mod_side_pkg::fifo_flags_t   m_src_flags_o,

   // Module side, destination path.
   input  logic                        m_dst_putn_i,
   input  mod_side_pkg::mod_entry_t    m_dst_i,
   output mod_side_pkg::fifo_flags_t   m_dst_flags_o,

   input  logic                        m_endn_i,
   output logic [`DMA_CH_OCNT_W-1:0]   ocnt_o
);

   import dma_side_pkg::*;
   import mod_side_pkg::*;

   src_entry_t  src_din;
   src_entry_t  src_head;
   mod_entry_t  dst_head;
   fifo_flags_t src_flags;
   fifo_flags_t dst_flags;
   logic        dst_at_end;
   logic        dst_pop;

   // The two DMA lanes and the last marker form one source entry.
   assign src_din.last = src_last_i;
   assign src_din.word = src_word_i;

   ch_fifo #(
      .payload_t (src_entry_t)
   ) src_fifo (
      .wb_clk_i (wb_clk_i),
      .m_reset  (m_reset),
      .push_i   (src_xfer_i),
      .pop_i    (!m_src_getn_i),
      .din_i    (src_din),
      .head_o   (src_head),
      .flags_o  (src_flags)
   );

   assign m_src_o.last = src_head.last;
   assign m_src_o.data = {src_head.word.hi, src_head.word.lo};

   // The module only sees the low end flags of its input FIFO.
   always_comb
   begin
      m_src_flags_o              = '0;
      m_src_flags_o.empty        = src_flags.empty;
      m_src_flags_o.almost_empty = src_flags.almost_empty;
   end

   // A final result parks at the head, and the DMA cannot pop it.
   // It stays there as the end marker until the next reset.
   assign dst_at_end = dst_head.last && !dst_flags.empty;
   assign dst_pop    = dst_xfer_i && !dst_at_end;

   ch_fifo #(
      .payload_t (mod_entry_t)
   ) dst_fifo (
      .wb_clk_i (wb_clk_i),
      .m_reset  (m_reset),
      .push_i   (!m_dst_putn_i),
      .pop_i    (dst_pop),
      .din_i    (m_dst_i),
      .head_o   (dst_head),
      .flags_o  (dst_flags)
   );

   assign dst_word_o.hi = dst_head.data[63:32];
   assign dst_word_o.lo = dst_head.data[31:0];

   // The module only sees the high end flags of its output FIFO.
   always_comb
   begin
      m_dst_flags_o             = '0;
      m_dst_flags_o.almost_full = dst_flags.almost_full;
      m_dst_flags_o.full        = dst_flags.full;
   end

   assign src_ctl_o.start = !src_flags.half_full;
   assign src_ctl_o.stop  = src_flags.almost_full;

   // Once the module is done, any leftover results are worth writing
   // out even when the FIFO is below half full.
   assign dst_ctl_o.start = dst_flags.half_full || (!m_endn_i && !dst_flags.empty);
   assign dst_ctl_o.stop  = dst_flags.almost_empty;
   assign dst_ctl_o.last  = dst_at_end;

   // Counts every put strobe of a non-final word, accepted or not.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         ocnt_o <= '0;
      else if (!m_dst_putn_i && !m_dst_i.last)
         ocnt_o <= ocnt_o + 1'b1;
   end

endmodule

// File: bench/dma_ch_assert.sv
`timescale 1ns/1ps

module dma_ch_assert (
   input logic                       wb_clk_i,
   input logic                       m_reset,
   input mod_side_pkg::fifo_flags_t  src_flags_i,
   input mod_side_pkg::fifo_flags_t  dst_flags_i,
   input dma_side_pkg::dma_dst_ctl_t dst_ctl_i
);

   src_empty_not_full: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      !(src_flags_i.empty && src_flags_i.full))
      else $error("Source FIFO reports empty and full at once");

   dst_empty_not_full: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      !(dst_flags_i.empty && dst_flags_i.full))
      else $error("Destination FIFO reports empty and full at once");

   // An empty FIFO is always within the almost margin.
   src_empty_almost: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      src_flags_i.empty |-> src_flags_i.almost_empty)
      else $error("Source FIFO empty without almost_empty");

   dst_empty_almost: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      dst_flags_i.empty |-> dst_flags_i.almost_empty)
      else $error("Destination FIFO empty without almost_empty");

   src_full_almost: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      src_flags_i.full |-> src_flags_i.almost_full)
      else $error("Source FIFO full without almost_full");

   dst_full_almost: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      dst_flags_i.full |-> dst_flags_i.almost_full)
      else $error("Destination FIFO full without almost_full");

   // The end marker needs an entry to sit on.
   dst_last_not_empty: assert property (@(posedge wb_clk_i) disable iff (m_reset)
      dst_ctl_i.last |-> !dst_flags_i.empty)
      else $error("End marker raised on an empty destination FIFO");

endmodule

bind dma_ch dma_ch_assert dma_ch_assert_i (
   .wb_clk_i    (wb_clk_i),
   .m_reset     (m_reset),
   .src_flags_i (src_flags),
   .dst_flags_i (dst_flags),
   .dst_ctl_i   (dst_ctl_o)
);

// File: bench/dma_ch_tb.sv
`timescale 1ns/1ps
`include "dma_ch_consts.svh"

module dma_ch_tb;

   import dma_side_pkg::*;
   import mod_side_pkg::*;

   localparam int DEPTH      = 1 << `DMA_CH_FIFO_AW;
   localparam int MARGIN     = `DMA_CH_ALMOST_MARGIN;
   localparam int WAIT_LIMIT = 4 * DEPTH;

   logic                      wb_clk_i;
   logic                      m_reset;
   logic                      src_xfer_i;
   logic                      src_last_i;
   dma_word_t                 src_word_i;
   dma_src_ctl_t              src_ctl_o;
   logic                      dst_xfer_i;
   dma_word_t                 dst_word_o;
   dma_dst_ctl_t              dst_ctl_o;
   logic                      m_src_getn_i;
   mod_entry_t                m_src_o;
   fifo_flags_t               m_src_flags_o;
   logic                      m_dst_putn_i;
   mod_entry_t                m_dst_i;
   fifo_flags_t               m_dst_flags_o;
   logic                      m_endn_i;
   logic [`DMA_CH_OCNT_W-1:0] ocnt_o;

   // Reference model of both FIFOs and of the result counter.
   src_entry_t                src_q[$];
   mod_entry_t                dst_q[$];
   logic [`DMA_CH_OCNT_W-1:0] ocnt_model;

   int    err_entry;
   int    err_word;
   int    err_flags;
   int    err_ctl;
   int    err_count;
   int    timeouts;
   logic  aborted;
   string test_name;

   dma_ch dma_ch_i (.*);

   initial
   begin
      wb_clk_i = 1'b0;
      forever #2 wb_clk_i = ~wb_clk_i;
   end

   function automatic fifo_flags_t flags_for(input int n);
      fifo_flags_t f;
      f.empty        = (n == 0);
      f.almost_empty = (n <= MARGIN);
      f.half_full    = (n >= DEPTH / 2);
      f.almost_full  = (n >= DEPTH - MARGIN);
      f.full         = (n == DEPTH);
      return f;
   endfunction

   task automatic check_mod_entry(input string what, input mod_entry_t exp,
                                  input mod_entry_t act);
      if (act !== exp)
      begin
         err_entry++;
         $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_dma_word(input string what, input dma_word_t exp, input dma_word_t act);
      if (act !== exp)
      begin
         err_word++;
         $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_flags(input string what, input fifo_flags_t exp, input fifo_flags_t act);
      if (act !== exp)
      begin
         err_flags++;
         $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_src_ctl(input string what, input dma_src_ctl_t exp,
                                input dma_src_ctl_t act);
      if (act !== exp)
      begin
         err_ctl++;
         $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_dst_ctl(input string what, input dma_dst_ctl_t exp,
                                input dma_dst_ctl_t act);
      if (act !== exp)
      begin
         err_ctl++;
         $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_count(input string what, input logic [`DMA_CH_OCNT_W-1:0] exp,
                              input logic [`DMA_CH_OCNT_W-1:0] act);
      if (act !== exp)
      begin
         err_count++;
         $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   // Compares every DUT output with the state the model holds after the last edge.
   task automatic check_outputs;
      fifo_flags_t  sf;
      fifo_flags_t  df;
      fifo_flags_t  exp_f;
      dma_src_ctl_t exp_sc;
      dma_dst_ctl_t exp_dc;
      mod_entry_t   exp_e;
      dma_word_t    exp_w;
      sf = flags_for(src_q.size());
      df = flags_for(dst_q.size());
      exp_f              = '0;
      exp_f.empty        = sf.empty;
      exp_f.almost_empty = sf.almost_empty;
      check_flags("m_src_flags_o", exp_f, m_src_flags_o);
      exp_f             = '0;
      exp_f.almost_full = df.almost_full;
      exp_f.full        = df.full;
      check_flags("m_dst_flags_o", exp_f, m_dst_flags_o);
      exp_sc.start = !sf.half_full;
      exp_sc.stop  = sf.almost_full;
      check_src_ctl("src_ctl_o", exp_sc, src_ctl_o);
      exp_dc.start = df.half_full || (!m_endn_i && !df.empty);
      exp_dc.stop  = df.almost_empty;
      exp_dc.last  = 1'b0;
      if (!df.empty)
         exp_dc.last = dst_q[0].last;
      check_dst_ctl("dst_ctl_o", exp_dc, dst_ctl_o);
      if (!sf.empty)
      begin
         exp_e.last = src_q[0].last;
         exp_e.data = {src_q[0].word.hi, src_q[0].word.lo};
         check_mod_entry("m_src_o", exp_e, m_src_o);
      end
      if (!df.empty)
      begin
         exp_w.hi = dst_q[0].data[63:32];
         exp_w.lo = dst_q[0].data[31:0];
         check_dma_word("dst_word_o", exp_w, dst_word_o);
      end
      check_count("ocnt_o", ocnt_model, ocnt_o);
   endtask

   task automatic drive_idle;
      src_xfer_i   = 1'b0;
      src_last_i   = 1'b0;
      src_word_i   = '0;
      m_src_getn_i = 1'b1;
      m_dst_putn_i = 1'b1;
      m_dst_i      = '0;
      dst_xfer_i   = 1'b0;
      m_endn_i     = 1'b1;
   endtask

   // One clock cycle: check at the falling edge, drive new inputs, then
   // advance the model to where the DUT will be after the next rising edge.
   task automatic cycle(input logic sx, input logic sl, input logic getn, input logic putn,
                        input logic dlast, input logic dx, input logic endn);
      src_entry_t se;
      logic       src_push;
      logic       src_pop;
      logic       dst_push;
      logic       dst_pop;
      @(negedge wb_clk_i);
      check_outputs();
      src_xfer_i   = sx;
      src_last_i   = sl;
      src_word_i   = {$urandom, $urandom};
      m_src_getn_i = getn;
      m_dst_putn_i = putn;
      m_dst_i.last = dlast;
      m_dst_i.data = {$urandom, $urandom};
      dst_xfer_i   = dx;
      m_endn_i     = endn;
      src_push = sx && (src_q.size() < DEPTH);
      src_pop  = !getn && (src_q.size() > 0);
      dst_push = !putn && (dst_q.size() < DEPTH);
      dst_pop  = dx && (dst_q.size() > 0) && !dst_q[0].last;
      se.last = sl;
      se.word = src_word_i;
      if (src_pop)
         void'(src_q.pop_front());
      if (src_push)
         src_q.push_back(se);
      if (dst_pop)
         void'(dst_q.pop_front());
      if (dst_push)
         dst_q.push_back(m_dst_i);
      if (!putn && !dlast)
         ocnt_model = ocnt_model + 1'b1;
   endtask

   task automatic apply_reset;
      test_name = "reset";
      m_reset   = 1'b1;
      drive_idle();
      src_q.delete();
      dst_q.delete();
      ocnt_model = '0;
      repeat (3) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      check_outputs();
      check_mod_entry("m_src_o", '0, m_src_o);
      check_dma_word("dst_word_o", '0, dst_word_o);
      m_reset = 1'b0;
   endtask

   task automatic random_traffic(input string name, input int n, input int push_pct,
                                 input int pop_pct);
      logic putn;
      test_name = name;
      for (int i = 0; i < n; i++)
      begin
         putn = !(($urandom % 100) < push_pct);
         // A final result is only offered with the put strobe high.
         cycle(($urandom % 100) < push_pct, ($urandom % 8) == 0,
               !(($urandom % 100) < pop_pct), putn, putn && (($urandom % 2) == 1),
               ($urandom % 100) < pop_pct, ($urandom % 10) != 0);
      end
   endtask

   task automatic fill_to_full;
      int n;
      test_name = "fill";
      n = 0;
      while (!(dma_ch_i.src_fifo.flags_o.full && m_dst_flags_o.full))
      begin
         if (n == WAIT_LIMIT)
         begin
            $display("Timeout: the FIFOs did not fill within %0d cycles", WAIT_LIMIT);
            timeouts++;
            aborted = 1'b1;
            return;
         end
         cycle(1'b1, (($urandom % 2) == 1), 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
         n++;
      end
      // Pushes on full FIFOs are dropped, but the rejected puts still count.
      repeat (8) cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
      // Push and pop together on a full FIFO accept only the pop.
      cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
      repeat (4) cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic drain_to_empty;
      int n;
      test_name = "drain";
      n = 0;
      while (!(m_src_flags_o.empty && dma_ch_i.dst_fifo.flags_o.empty))
      begin
         if (n == WAIT_LIMIT)
         begin
            $display("Timeout: the FIFOs did not drain within %0d cycles", WAIT_LIMIT);
            timeouts++;
            aborted = 1'b1;
            return;
         end
         cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
         n++;
      end
      // Pops on empty FIFOs change nothing, and dst start stays low.
      repeat (8) cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
      // Push and pop together on an empty FIFO accept only the push.
      cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
      repeat (4) cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic end_marker;
      int n;
      test_name = "end_marker";
      repeat (5) cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
      cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
      // With the job done, start rises although the FIFO is below half full.
      repeat (3) cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      n = 0;
      while (!dst_ctl_o.last)
      begin
         if (n == WAIT_LIMIT)
         begin
            $display("Timeout: the end marker did not reach the head of the FIFO");
            timeouts++;
            aborted = 1'b1;
            return;
         end
         cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
         n++;
      end
      repeat (6) cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
   endtask

   initial
   begin
      void'($urandom(82333));
      err_entry = 0;
      err_word  = 0;
      err_flags = 0;
      err_ctl   = 0;
      err_count = 0;
      timeouts  = 0;
      aborted   = 1'b0;
      apply_reset();
      random_traffic("random_fill", 600, 70, 30);
      random_traffic("random_drain", 600, 30, 70);
      if (!aborted)
         fill_to_full();
      if (!aborted)
         drain_to_empty();
      if (!aborted)
         end_marker();
      if (!aborted)
      begin
         apply_reset();
         random_traffic("after_reset", 300, 50, 50);
         cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
      end
      $display("Error counts: entry %0d, word %0d, flags %0d, ctl %0d, count %0d, timeout %0d",
               err_entry, err_word, err_flags, err_ctl, err_count, timeouts);
      if (err_entry + err_word + err_flags + err_ctl + err_count + timeouts == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: project.f
+incdir+common
common/dma_side_pkg.sv
common/mod_side_pkg.sv
src/tpram.sv
ch_fifo/ch_fifo.sv
src/dma_ch.sv
bench/dma_ch_assert.sv
bench/dma_ch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the channel testbench with Verilator, runs it and checks the log.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dma_ch_sim
LOG=sim.log

verilator --binary --assert -j 0 --top-module dma_ch_tb \
   -f project.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
